// ==== verilog/mci_pkg.sv ====
// Shared types and fixed address map for the AXI subordinate; all windows are word aligned
package mci_pkg;

    // Plain vector types for the AXI side
    typedef logic [31:0] axi_addr_t;
    typedef logic [31:0] axi_data_t;
    typedef logic [3:0]  axi_strb_t;
    typedef logic [3:0]  axi_id_t;
    typedef logic [1:0]  axi_resp_t;

    // Response codes
    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;

    // Address map, base in bytes and size in KB
    localparam axi_addr_t MCU_SRAM_BASE    = 32'h0020_0000;
    localparam int        MCU_SRAM_SIZE_KB = 1024;
    localparam axi_addr_t MBOX0_BASE       = 32'h0040_0000;
    localparam int        MBOX0_SIZE_KB    = 4;
    localparam axi_addr_t MBOX1_BASE       = 32'h0050_0000;
    localparam int        MBOX1_SIZE_KB    = 4;

    // Both mailboxes share one size, so one word count
    localparam int MBOX_WORDS = MBOX0_SIZE_KB * 1024 / 4;
    typedef logic [$clog2(MBOX_WORDS)-1:0] mbox_idx_t;

    // AXI channel payloads
    typedef struct packed {
        axi_addr_t addr;
        axi_id_t   id;
    } axi_aw_t;

    typedef struct packed {
        axi_data_t data;
        axi_strb_t strb;
    } axi_w_t;

    typedef struct packed {
        axi_id_t   id;
        axi_resp_t resp;
    } axi_b_t;

    typedef struct packed {
        axi_addr_t addr;
        axi_id_t   id;
    } axi_ar_t;

    typedef struct packed {
        axi_id_t   id;
        axi_data_t data;
        axi_resp_t resp;
    } axi_r_t;

    // Simplex internal request, also used on the SRAM port
    typedef struct packed {
        axi_addr_t addr;
        logic      write;
        axi_data_t wdata;
        axi_strb_t wstrb;
        axi_id_t   id;
    } cif_req_t;

endpackage

// ==== verilog/mci_mbox_mem.sv ====
// Byte-writable mailbox storage with combinational read and a full clear on reset
`timescale 1ns/1ps

module mci_mbox_mem (
    input  logic                clk,
    input  logic                reset,
    input  logic                we,
    input  mci_pkg::mbox_idx_t  idx,
    input  mci_pkg::axi_data_t  wdata,
    input  mci_pkg::axi_strb_t  wstrb,
    output mci_pkg::axi_data_t  rdata
);
    import mci_pkg::*;

    axi_data_t mem [MBOX_WORDS];

    // Clear on reset so every word reads a known value
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < MBOX_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            // Only strobed bytes change
            for (int n = 0; n < $bits(axi_strb_t); n++) begin
                if (wstrb[n]) begin
                    mem[idx][n*8 +: 8] <= wdata[n*8 +: 8];
                end
            end
        end
    end

    // Same-cycle read
    assign rdata = mem[idx];

endmodule

// ==== verilog/mci_axi_sub.sv ====
// Single-beat AXI subordinate with one transaction in flight and no burst or exclusive support
`timescale 1ns/1ps

module mci_axi_sub (
    input  logic                clk,
    input  logic                reset,

    // Write address and data
    input  mci_pkg::axi_aw_t    aw,
    input  logic                awvalid,
    output logic                awready,
    input  mci_pkg::axi_w_t     w,
    input  logic                wvalid,
    output logic                wready,

    // Write response
    output mci_pkg::axi_b_t     b,
    output logic                bvalid,
    input  logic                bready,

    // Read address and data
    input  mci_pkg::axi_ar_t    ar,
    input  logic                arvalid,
    output logic                arready,
    output mci_pkg::axi_r_t     r,
    output logic                rvalid,
    input  logic                rready,

    // Internal request
    output logic                cif_dv,
    output mci_pkg::cif_req_t   cif_req,
    input  logic                cif_hold,
    input  mci_pkg::axi_data_t  cif_rdata,
    input  logic                cif_error
);
    import mci_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        RESP
    } state_t;

    state_t state;
    // Set when the last served transaction was a write
    logic   last_write;
    logic   wr_pend;
    logic   rd_pend;
    logic   pick_write;
    logic   wr_hs;
    logic   rd_hs;
    logic   req_done;
    logic   resp_done;

    // A write needs address and data together
    assign wr_pend    = awvalid && wvalid;
    assign rd_pend    = arvalid;
    // Alternate when both are pending
    assign pick_write = wr_pend && (!rd_pend || !last_write);

    assign wr_hs     = awvalid && awready && wvalid && wready;
    assign rd_hs     = arvalid && arready;
    assign req_done  = cif_dv && !cif_hold;
    assign resp_done = (bvalid && bready) || (rvalid && rready);

    // Request is live for the whole REQ state
    assign cif_dv = (state == REQ);

    // Control path
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= IDLE;
            awready    <= 1'b0;
            wready     <= 1'b0;
            arready    <= 1'b0;
            bvalid     <= 1'b0;
            rvalid     <= 1'b0;
            last_write <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (wr_hs) begin
                        awready    <= 1'b0;
                        wready     <= 1'b0;
                        last_write <= 1'b1;
                        state      <= REQ;
                    end else if (rd_hs) begin
                        arready    <= 1'b0;
                        last_write <= 1'b0;
                        state      <= REQ;
                    end else if (!awready && !arready) begin
                        // Ready goes up one cycle after the choice
                        if (pick_write) begin
                            awready <= 1'b1;
                            wready  <= 1'b1;
                        end else if (rd_pend) begin
                            arready <= 1'b1;
                        end
                    end
                end
                REQ: begin
                    if (req_done) begin
                        if (cif_req.write) begin
                            bvalid <= 1'b1;
                        end else begin
                            rvalid <= 1'b1;
                        end
                        state <= RESP;
                    end
                end
                RESP: begin
                    // Hold the response until the manager takes it
                    if (resp_done) begin
                        bvalid <= 1'b0;
                        rvalid <= 1'b0;
                        state  <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Request capture and response payloads
    always_ff @(posedge clk) begin
        if (wr_hs) begin
            cif_req.addr  <= aw.addr;
            cif_req.write <= 1'b1;
            cif_req.wdata <= w.data;
            cif_req.wstrb <= w.strb;
            cif_req.id    <= aw.id;
        end else if (rd_hs) begin
            cif_req.addr  <= ar.addr;
            cif_req.write <= 1'b0;
            cif_req.wdata <= '0;
            cif_req.wstrb <= '0;
            cif_req.id    <= ar.id;
        end
        if (req_done && cif_req.write) begin
            b.id   <= cif_req.id;
            b.resp <= cif_error ? RESP_SLVERR : RESP_OKAY;
        end
        if (req_done && !cif_req.write) begin
            r.id   <= cif_req.id;
            // No stale data leaks out on an error
            r.data <= cif_error ? '0 : cif_rdata;
            r.resp <= cif_error ? RESP_SLVERR : RESP_OKAY;
        end
    end

endmodule

// ==== verilog/mci_axi_sub_decode.sv ====
// Combinational address decoder over fixed package windows; unmapped addresses complete with an error
`timescale 1ns/1ps

module mci_axi_sub_decode (
    // Request from the subordinate
    input  logic                cif_dv,
    input  mci_pkg::cif_req_t   cif_req,
    output logic                cif_hold,
    output mci_pkg::axi_data_t  cif_rdata,
    output logic                cif_error,

    // MCU SRAM port
    output logic                sram_dv,
    output mci_pkg::cif_req_t   sram_req,
    input  logic                sram_hold,
    input  mci_pkg::axi_data_t  sram_rdata,
    input  logic                sram_error,

    // Mailbox ports
    output logic                mbox0_we,
    output logic                mbox1_we,
    output mci_pkg::mbox_idx_t  mbox_idx,
    output mci_pkg::axi_data_t  mbox_wdata,
    output mci_pkg::axi_strb_t  mbox_wstrb,
    input  mci_pkg::axi_data_t  mbox0_rdata,
    input  mci_pkg::axi_data_t  mbox1_rdata
);
    import mci_pkg::*;

    logic sel_sram;
    logic sel_mbox0;
    logic sel_mbox1;

    // Base inclusive, end exclusive
    function automatic logic in_window(axi_addr_t addr, axi_addr_t base, int size_kb);
        return (addr >= base) && (addr < base + axi_addr_t'(size_kb * 1024));
    endfunction

    // Windows do not overlap, so at most one select is high
    assign sel_sram  = in_window(cif_req.addr, MCU_SRAM_BASE, MCU_SRAM_SIZE_KB);
    assign sel_mbox0 = in_window(cif_req.addr, MBOX0_BASE, MBOX0_SIZE_KB);
    assign sel_mbox1 = in_window(cif_req.addr, MBOX1_BASE, MBOX1_SIZE_KB);

    // SRAM sees its own offset
    assign sram_dv = cif_dv && sel_sram;
    always_comb begin
        sram_req      = cif_req;
        sram_req.addr = cif_req.addr - MCU_SRAM_BASE;
    end

    // Mailboxes never stall, so the write lands on the completing edge
    assign mbox0_we   = cif_dv && sel_mbox0 && cif_req.write;
    assign mbox1_we   = cif_dv && sel_mbox1 && cif_req.write;
    // Word index from the byte address
    assign mbox_idx   = mbox_idx_t'(cif_req.addr >> 2);
    assign mbox_wdata = cif_req.wdata;
    assign mbox_wstrb = cif_req.wstrb;

    // Return path mux
    always_comb begin
        cif_rdata = '0;
        cif_hold  = 1'b0;
        cif_error = 1'b0;
        if (sel_sram) begin
            cif_rdata = sram_rdata;
            cif_hold  = sram_hold;
            cif_error = sram_error;
        end else if (sel_mbox0) begin
            cif_rdata = mbox0_rdata;
        end else if (sel_mbox1) begin
            cif_rdata = mbox1_rdata;
        end else begin
            // Unmapped, finish at once with no target touched
            cif_error = 1'b1;
        end
    end

endmodule

// ==== verilog/mci_axi_sub_top.sv ====
// AXI subordinate top with two internal mailboxes and an external MCU SRAM request port
`timescale 1ns/1ps

module mci_axi_sub_top (
    input  logic                clk,
    input  logic                reset,

    // AXI write side
    input  mci_pkg::axi_aw_t    aw,
    input  logic                awvalid,
    output logic                awready,
    input  mci_pkg::axi_w_t     w,
    input  logic                wvalid,
    output logic                wready,
    output mci_pkg::axi_b_t     b,
    output logic                bvalid,
    input  logic                bready,

    // AXI read side
    input  mci_pkg::axi_ar_t    ar,
    input  logic                arvalid,
    output logic                arready,
    output mci_pkg::axi_r_t     r,
    output logic                rvalid,
    input  logic                rready,

    // MCU SRAM
    output logic                sram_dv,
    output mci_pkg::cif_req_t   sram_req,
    input  logic                sram_hold,
    input  mci_pkg::axi_data_t  sram_rdata,
    input  logic                sram_error
);
    import mci_pkg::*;

    // Subordinate to decoder
    logic       cif_dv;
    cif_req_t   cif_req;
    logic       cif_hold;
    axi_data_t  cif_rdata;
    logic       cif_error;

    // Decoder to mailboxes
    logic       mbox0_we;
    logic       mbox1_we;
    mbox_idx_t  mbox_idx;
    axi_data_t  mbox_wdata;
    axi_strb_t  mbox_wstrb;
    axi_data_t  mbox0_rdata;
    axi_data_t  mbox1_rdata;

    // Full-duplex AXI down to one request stream
    mci_axi_sub mci_axi_sub_i (
        .clk       (clk),
        .reset     (reset),
        .aw        (aw),
        .awvalid   (awvalid),
        .awready   (awready),
        .w         (w),
        .wvalid    (wvalid),
        .wready    (wready),
        .b         (b),
        .bvalid    (bvalid),
        .bready    (bready),
        .ar        (ar),
        .arvalid   (arvalid),
        .arready   (arready),
        .r         (r),
        .rvalid    (rvalid),
        .rready    (rready),
        .cif_dv    (cif_dv),
        .cif_req   (cif_req),
        .cif_hold  (cif_hold),
        .cif_rdata (cif_rdata),
        .cif_error (cif_error)
    );

    // Route to SRAM or a mailbox
    mci_axi_sub_decode mci_axi_sub_decode_i (
        .cif_dv      (cif_dv),
        .cif_req     (cif_req),
        .cif_hold    (cif_hold),
        .cif_rdata   (cif_rdata),
        .cif_error   (cif_error),
        .sram_dv     (sram_dv),
        .sram_req    (sram_req),
        .sram_hold   (sram_hold),
        .sram_rdata  (sram_rdata),
        .sram_error  (sram_error),
        .mbox0_we    (mbox0_we),
        .mbox1_we    (mbox1_we),
        .mbox_idx    (mbox_idx),
        .mbox_wdata  (mbox_wdata),
        .mbox_wstrb  (mbox_wstrb),
        .mbox0_rdata (mbox0_rdata),
        .mbox1_rdata (mbox1_rdata)
    );

    // Mailbox 0
    mci_mbox_mem mbox0_i (
        .clk   (clk),
        .reset (reset),
        .we    (mbox0_we),
        .idx   (mbox_idx),
        .wdata (mbox_wdata),
        .wstrb (mbox_wstrb),
        .rdata (mbox0_rdata)
    );

    // Mailbox 1 shares index and write data, separate enable
    mci_mbox_mem mbox1_i (
        .clk   (clk),
        .reset (reset),
        .we    (mbox1_we),
        .idx   (mbox_idx),
        .wdata (mbox_wdata),
        .wstrb (mbox_wstrb),
        .rdata (mbox1_rdata)
    );

endmodule

// ==== testbench/mci_axi_sub_top_properties.sv ====
// Protocol checks bound into the top level; relies on the internal cif_* wire names of the top
`timescale 1ns/1ps

module mci_axi_sub_top_properties (
    input logic               clk,
    input logic               reset,
    input logic               awready,
    input logic               wready,
    input logic               arready,
    input mci_pkg::axi_b_t    b,
    input logic               bvalid,
    input logic               bready,
    input mci_pkg::axi_r_t    r,
    input logic               rvalid,
    input logic               rready,
    input logic               cif_dv,
    input mci_pkg::cif_req_t  cif_req,
    input logic               cif_hold,
    input logic               sram_dv
);
    import mci_pkg::*;

    // Responses hold until taken
    a_b_stable: assert property (@(posedge clk) disable iff (reset)
        bvalid && !bready |=> bvalid && $stable(b))
        else $error("write response dropped or changed before bready");
    a_r_stable: assert property (@(posedge clk) disable iff (reset)
        rvalid && !rready |=> rvalid && $stable(r))
        else $error("read response dropped or changed before rready");

    // One transaction in flight
    a_one_resp: assert property (@(posedge clk) disable iff (reset)
        !(bvalid && rvalid))
        else $error("write and read responses valid together");
    a_no_accept: assert property (@(posedge clk) disable iff (reset)
        (bvalid || rvalid) |-> !(awready || wready || arready))
        else $error("address accepted while a response is pending");

    // Stalled request stays put
    a_cif_stable: assert property (@(posedge clk) disable iff (reset)
        cif_dv && cif_hold |=> cif_dv && $stable(cif_req))
        else $error("internal request changed while held");

    a_reset_out: assert property (@(posedge clk)
        reset |=> !(awready || wready || arready || bvalid || rvalid || cif_dv || sram_dv))
        else $error("outputs not low after reset");

endmodule

bind mci_axi_sub_top mci_axi_sub_top_properties mci_axi_sub_top_properties_i (
    .clk      (clk),
    .reset    (reset),
    .awready  (awready),
    .wready   (wready),
    .arready  (arready),
    .b        (b),
    .bvalid   (bvalid),
    .bready   (bready),
    .r        (r),
    .rvalid   (rvalid),
    .rready   (rready),
    .cif_dv   (cif_dv),
    .cif_req  (cif_req),
    .cif_hold (cif_hold),
    .sram_dv  (sram_dv)
);

// ==== testbench/mci_axi_sub_top_tb.sv ====
// Fixed seed; SRAM model stalls 0 to 3 cycles and flags offsets at or above 0x8_0000 as errors
`timescale 1ns/1ps

module mci_axi_sub_top_tb;
    import mci_pkg::*;

    localparam int SRAM_OPS = 40;
    localparam int PAIR_OPS = 30;
    // Twelve directed transactions plus the random runs
    localparam int NUM_TXNS = 12 + SRAM_OPS + 2 * PAIR_OPS;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    axi_aw_t     aw = '0;
    logic        awvalid = 1'b0;
    logic        awready;
    axi_w_t      w = '0;
    logic        wvalid = 1'b0;
    logic        wready;
    axi_b_t      b;
    logic        bvalid;
    logic        bready = 1'b1;
    axi_ar_t     ar = '0;
    logic        arvalid = 1'b0;
    logic        arready;
    axi_r_t      r;
    logic        rvalid;
    logic        rready = 1'b1;
    logic        sram_dv;
    cif_req_t    sram_req;
    logic        sram_hold = 1'b0;
    axi_data_t   sram_rdata;
    logic        sram_error;

    int          resp_count = 0;
    logic        bp_en = 1'b0;
    int unsigned stall = 0;
    axi_addr_t   sram_exp_offs;
    axi_id_t     sram_exp_id;
    axi_addr_t   addr;
    // Outstanding write and read as issued
    axi_aw_t     exp_aw;
    axi_w_t      exp_w;
    axi_ar_t     exp_ar;
    // Reference contents and SRAM model storage, both keyed by word address
    axi_data_t   ref_mem [logic [29:0]];
    axi_data_t   sram_mem [logic [29:0]];

    mci_axi_sub_top mci_axi_sub_top_i (.*);

    always #5 clk = ~clk;

    function automatic axi_data_t merge_bytes(axi_data_t old, axi_data_t data, axi_strb_t strb);
        axi_data_t word;
        word = old;
        for (int n = 0; n < 4; n++) begin
            if (strb[n]) begin
                word[n*8 +: 8] = data[n*8 +: 8];
            end
        end
        return word;
    endfunction

    // Mapped means SRAM below the model's error boundary, or one of the 4 KB mailboxes
    function automatic logic error_expected(axi_addr_t a);
        if (a >= MCU_SRAM_BASE && a - MCU_SRAM_BASE < 32'h0008_0000) begin
            return 1'b0;
        end
        return !(a[31:12] == MBOX0_BASE[31:12] || a[31:12] == MBOX1_BASE[31:12]);
    endfunction

    function automatic axi_data_t ref_read(axi_addr_t a);
        return ref_mem.exists(a[31:2]) ? ref_mem[a[31:2]] : '0;
    endfunction

    function automatic axi_data_t sram_word(axi_addr_t a);
        return sram_mem.exists(a[31:2]) ? sram_mem[a[31:2]] : '0;
    endfunction

    function automatic axi_addr_t random_addr();
        axi_addr_t offs;
        offs = axi_addr_t'($urandom_range(0, 15)) << 2;
        case ($urandom_range(0, 3))
            0: return MBOX0_BASE + offs;
            1: return MBOX1_BASE + offs;
            2: return MCU_SRAM_BASE + offs;
            default: return 32'h0060_0000 + offs;
        endcase
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
        fail_run($sformatf("mismatch at %0t: %s expected 0x%0h, actual 0x%0h",
                           $time, name, exp, act));
    endtask

    task automatic start_write(input axi_addr_t a, input axi_data_t data, input axi_strb_t strb);
        exp_aw = '{addr: a, id: axi_id_t'($urandom)};
        exp_w  = '{data: data, strb: strb};
        aw      <= exp_aw;
        w       <= exp_w;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
    endtask

    task automatic start_read(input axi_addr_t a);
        exp_ar = '{addr: a, id: axi_id_t'($urandom)};
        ar      <= exp_ar;
        arvalid <= 1'b1;
    endtask

    // Reference takes the write only once B is accepted
    task automatic finish_write();
        axi_resp_t exp_resp;
        do @(posedge clk); while (!awready);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        do @(posedge clk); while (!(bvalid && bready));
        exp_resp = error_expected(exp_aw.addr) ? RESP_SLVERR : RESP_OKAY;
        assert (b.id == exp_aw.id) else mismatch("b.id", 32'(exp_aw.id), 32'(b.id));
        assert (b.resp == exp_resp) else mismatch("b.resp", 32'(exp_resp), 32'(b.resp));
        if (exp_resp == RESP_OKAY) begin
            ref_mem[exp_aw.addr[31:2]] =
                merge_bytes(ref_read(exp_aw.addr), exp_w.data, exp_w.strb);
        end
    endtask

    task automatic finish_read();
        axi_resp_t exp_resp;
        axi_data_t exp_data;
        do @(posedge clk); while (!arready);
        arvalid <= 1'b0;
        do @(posedge clk); while (!(rvalid && rready));
        exp_resp = error_expected(exp_ar.addr) ? RESP_SLVERR : RESP_OKAY;
        exp_data = (exp_resp == RESP_OKAY) ? ref_read(exp_ar.addr) : '0;
        assert (r.id == exp_ar.id) else mismatch("r.id", 32'(exp_ar.id), 32'(r.id));
        assert (r.resp == exp_resp) else mismatch("r.resp", 32'(exp_resp), 32'(r.resp));
        assert (r.data == exp_data) else mismatch("r.data", exp_data, r.data);
    endtask

    task automatic do_write(input axi_addr_t a, input axi_data_t data, input axi_strb_t strb);
        start_write(a, data, strb);
        finish_write();
    endtask

    task automatic do_read(input axi_addr_t a);
        start_read(a);
        finish_read();
    endtask

    // SRAM answers in the same cycle as its request, errors at and above the boundary
    always_comb begin
        sram_error = 1'b0;
        sram_rdata = '0;
        if (sram_dv) begin
            sram_error = (sram_req.addr >= 32'h0008_0000);
            sram_rdata = sram_word(sram_req.addr);
        end
    end

    // Hold count for the next SRAM request, 0 to 3, drawn as each one completes
    always @(posedge clk) begin
        if (sram_dv && !sram_hold) begin
            // Offset and ID rebuilt from the transaction in flight
            sram_exp_offs = (sram_req.write ? exp_aw.addr : exp_ar.addr) - MCU_SRAM_BASE;
            sram_exp_id   = sram_req.write ? exp_aw.id : exp_ar.id;
            assert (sram_exp_offs < 32'(MCU_SRAM_SIZE_KB * 1024))
                else fail_run("SRAM port got a request for an address outside its window");
            assert (sram_req.addr == sram_exp_offs)
                else mismatch("sram_req.addr", sram_exp_offs, sram_req.addr);
            assert (sram_req.id == sram_exp_id)
                else mismatch("sram_req.id", 32'(sram_exp_id), 32'(sram_req.id));
            if (sram_req.write && !sram_error) begin
                sram_mem[sram_req.addr[31:2]] =
                    merge_bytes(sram_word(sram_req.addr), sram_req.wdata, sram_req.wstrb);
            end
            stall = $urandom_range(0, 3);
            sram_hold <= (stall != 0);
        end else if (sram_dv) begin
            stall = stall - 1;
            sram_hold <= (stall != 0);
        end
    end

    // Ready low about one cycle in three while back-pressure is on
    always @(posedge clk) begin
        bready <= !bp_en || ($urandom_range(0, 2) != 0);
        rready <= !bp_en || ($urandom_range(0, 2) != 0);
    end

    // Every B and R handshake counts, so a spurious response shows up at the end
    always @(posedge clk) begin
        if (!reset && bvalid && bready) begin
            resp_count++;
        end
        if (!reset && rvalid && rready) begin
            resp_count++;
        end
    end

    initial begin
        void'($urandom(1));
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        // Full write, read back, then partial write over it
        do_write(MBOX0_BASE + 32'h40, 32'hA5A5_1234, 4'hF);
        do_read(MBOX0_BASE + 32'h40);
        do_write(MBOX0_BASE + 32'h40, 32'h00FF_EE00, 4'b0110);
        do_read(MBOX0_BASE + 32'h40);
        // Same offset in mailbox 1 must not reach mailbox 0
        do_write(MBOX1_BASE + 32'h40, 32'hDEAD_BEEF, 4'hF);
        do_read(MBOX0_BASE + 32'h40);
        do_read(MBOX1_BASE + 32'h40);
        // SRAM under random stalls, small window so reads hit earlier writes
        repeat (SRAM_OPS) begin
            addr = MCU_SRAM_BASE + (axi_addr_t'($urandom_range(0, 15)) << 2);
            if ($urandom_range(0, 1) == 1) begin
                do_write(addr, $urandom, axi_strb_t'($urandom));
            end else begin
                do_read(addr);
            end
        end
        do_write(MCU_SRAM_BASE + 32'h0008_0010, 32'h1111_2222, 4'hF);
        do_read(MCU_SRAM_BASE + 32'h0008_0010);
        // Unmapped write would alias mailbox 0 word 0x10 if it leaked through
        do_write(32'h0040_1040, 32'hBAD0_BAD0, 4'hF);
        do_read(32'h0030_0000);
        do_read(MBOX0_BASE + 32'h40);
        // Writes and reads issued together under back-pressure
        bp_en <= 1'b1;
        repeat (PAIR_OPS) begin
            addr = random_addr();
            start_write(addr, $urandom, axi_strb_t'($urandom));
            start_read(($urandom_range(0, 1) == 1) ? addr : random_addr());
            fork
                finish_write();
                finish_read();
            join
        end
        repeat (2) @(posedge clk);
        if (resp_count == NUM_TXNS) begin
            $display("Everything OK");
            $finish;
        end else begin
            mismatch("resp_count", NUM_TXNS, resp_count);
        end
    end

    // Watchdog
    initial begin
        repeat (200 * NUM_TXNS) @(posedge clk);
        fail_run("watchdog expired, the run hung waiting for a handshake");
    end

endmodule

// ==== mci_axi_sub_top.f ====
verilog/mci_pkg.sv
verilog/mci_mbox_mem.sv
verilog/mci_axi_sub.sv
verilog/mci_axi_sub_decode.sv
verilog/mci_axi_sub_top.sv
testbench/mci_axi_sub_top_properties.sv
testbench/mci_axi_sub_top_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= mci_axi_sub_top_tb
FILELIST  ?= mci_axi_sub_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Something failed" $(LOG); then exit 1; fi
	@if ! grep -q "Everything OK" $(LOG); then echo "run ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
